// File: src/gmac_defs.svh
`ifndef GMAC_DEFS_SVH
`define GMAC_DEFS_SVH

// Register word indexes, taken from address bits 12:2
`define GMAC_REG_CORE_TYPE       11'd0
`define GMAC_REG_TX_RX_MAX_BUF   11'd1
`define GMAC_REG_WORD_LENGTHS    11'd2
`define GMAC_REG_MAC_ADDR_1      11'd3
`define GMAC_REG_MAC_ADDR_0      11'd4
`define GMAC_REG_IP_ADDR         11'd5
`define GMAC_REG_GATEWAY_ADDR    11'd6
`define GMAC_REG_NETMASK         11'd7
`define GMAC_REG_MC_RECV_IP      11'd8
`define GMAC_REG_MC_RECV_IP_MASK 11'd9
`define GMAC_REG_TX_RX_BUF       11'd10
`define GMAC_REG_PROMIS_EN       11'd11
`define GMAC_REG_PMASK_PORT      11'd12
`define GMAC_REG_PHY_STATUS_1    11'd13
`define GMAC_REG_PHY_STATUS_0    11'd14
`define GMAC_REG_PHY_CONTROL_1   11'd15
`define GMAC_REG_PHY_CONTROL_0   11'd16
`define GMAC_REG_ARP_SIZE        11'd17
`define GMAC_REG_TX_PKT_CNT      11'd18
`define GMAC_REG_RX_PKT_CNT      11'd19
`define GMAC_REG_RX_BAD_CNT      11'd20
`define GMAC_REG_COUNT_RESET     11'd21
// ARP window laid out like the AXI variant
`define GMAC_REG_ARP_WE          11'd1024
`define GMAC_REG_ARP_WDATA       11'd1026
`define GMAC_REG_ARP_WADDR       11'd1027
`define GMAC_REG_ARP_RADDR       11'd1028
`define GMAC_REG_ARP_RDATA       11'd1029

`define GMAC_REGS_LOW            32'h0000_0000
`define GMAC_REGS_HIGH           32'h0000_1FFF

// Reset defaults
`define GMAC_DEF_MAC             48'h02c0_ffee_0001
`define GMAC_DEF_IP              32'hc0a8_0a02
`define GMAC_DEF_PORT            16'h2710
`define GMAC_DEF_GATEWAY         32'hc0a8_0a01
`define GMAC_DEF_MC_IP           32'he000_0001
`define GMAC_DEF_MC_MASK         32'hffff_fff0

`define GMAC_CORE_TYPE_WORD      32'h0001_0002  // Rev 1, type 2
`define GMAC_MAX_BUF_WORD        32'h0800_0800  // TX 2048, RX 2048
`define GMAC_WORD_SIZE_WORD      32'h0008_0008

`define GMAC_ARP_DEPTH           256

`endif

// File: src/gmac_pkg.sv
`default_nettype none

package gmac_pkg;

  // Word index within the register window
  typedef logic [10:0] reg_idx_t;

  typedef logic [47:0] mac_addr_t;

  // Also used for netmask and multicast mask
  typedef logic [31:0] ip_addr_t;

  typedef logic [15:0] udp_port_t;

  // One of 256 ARP entries
  typedef logic [7:0] arp_idx_t;

  typedef logic [31:0] stat_cnt_t;

endpackage

`default_nettype wire

// File: src/gmac_arp_cache.sv
`timescale 1ns/1ps
`default_nettype none
`include "gmac_defs.svh"

module gmac_arp_cache (
  input  logic               wb_clk_i,
  input  logic               wr_i,
  input  gmac_pkg::arp_idx_t waddr_i,
  input  logic [31:0]        wdata_i,
  input  gmac_pkg::arp_idx_t raddr_i,
  input  gmac_pkg::arp_idx_t lookup_idx_i,
  output logic [31:0]        rdata_o,
  output logic [31:0]        lookup_data_o
);

  logic [31:0] mem [`GMAC_ARP_DEPTH];

  always_ff @(posedge wb_clk_i) begin
    if (wr_i)
      mem[waddr_i] <= wdata_i;
  end

  // Bus side read, always enabled
  always_ff @(posedge wb_clk_i) begin
    rdata_o <= mem[raddr_i];
  end

  // Packet core lookup
  always_ff @(posedge wb_clk_i) begin
    lookup_data_o <= mem[lookup_idx_i];
  end

endmodule

`default_nettype wire

// File: src/gmac_stat_counters.sv
`timescale 1ns/1ps
`default_nettype none

module gmac_stat_counters (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                clr_i,
  input  logic                tx_pkt_i,
  input  logic                rx_pkt_i,
  input  logic                rx_bad_pkt_i,
  output gmac_pkg::stat_cnt_t tx_cnt_o,
  output gmac_pkg::stat_cnt_t rx_cnt_o,
  output gmac_pkg::stat_cnt_t rx_bad_cnt_o
);
  import gmac_pkg::*;

  localparam int NUM_CNT = 3;

  stat_cnt_t          cnt_q [NUM_CNT];
  logic [NUM_CNT-1:0] pkt;

  assign pkt = {rx_bad_pkt_i, rx_pkt_i, tx_pkt_i};

  always_ff @(posedge wb_clk_i) begin
    for (int i = 0; i < NUM_CNT; i++) begin
      if (wb_rst_i || clr_i) begin
        cnt_q[i] <= '0;  // Clear wins over a pulse
      end else if (pkt[i] && (cnt_q[i] != '1)) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;  // Stick at max
      end
    end
  end

  assign tx_cnt_o     = cnt_q[0];
  assign rx_cnt_o     = cnt_q[1];
  assign rx_bad_cnt_o = cnt_q[2];

endmodule

`default_nettype wire

// File: src/gmac_wb_attach.sv
`timescale 1ns/1ps
`default_nettype none
`include "gmac_defs.svh"

module gmac_wb_attach #(
  parameter logic [47:0] FABRIC_MAC      = `GMAC_DEF_MAC,
  parameter logic [31:0] FABRIC_IP       = `GMAC_DEF_IP,
  parameter logic [15:0] FABRIC_PORT     = `GMAC_DEF_PORT,
  parameter logic [31:0] FABRIC_GATEWAY  = `GMAC_DEF_GATEWAY,
  parameter logic        FABRIC_ENABLE   = 1'b0,
  parameter logic [31:0] MC_RECV_IP      = `GMAC_DEF_MC_IP,
  parameter logic [31:0] MC_RECV_IP_MASK = `GMAC_DEF_MC_MASK
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic [31:0]          wb_adr_i,
  input  logic [3:0]           wb_sel_i,
  input  logic [31:0]          wb_dat_i,
  input  logic                 wb_we_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  output logic [31:0]          wb_dat_o,
  output logic                 wb_ack_o,
  input  logic                 link_up_i,
  output gmac_pkg::mac_addr_t  mac_addr_o,
  output gmac_pkg::ip_addr_t   local_ip_o,
  output gmac_pkg::ip_addr_t   gateway_o,
  output gmac_pkg::ip_addr_t   netmask_o,
  output gmac_pkg::ip_addr_t   mc_ip_o,
  output gmac_pkg::ip_addr_t   mc_mask_o,
  output gmac_pkg::udp_port_t  udp_port_o,
  output logic                 fabric_en_o,
  output logic                 soft_reset_o,
  output logic                 count_clr_o,
  input  gmac_pkg::stat_cnt_t  tx_pkt_cnt_i,
  input  gmac_pkg::stat_cnt_t  rx_pkt_cnt_i,
  input  gmac_pkg::stat_cnt_t  rx_bad_cnt_i,
  output logic                 arp_wr_o,
  output gmac_pkg::arp_idx_t   arp_waddr_o,
  output logic [31:0]          arp_wdata_o,
  output gmac_pkg::arp_idx_t   arp_raddr_o,
  input  logic [31:0]          arp_rdata_i
);
  import gmac_pkg::*;

  logic        ack_q;
  logic        req;
  logic [31:0] win_ofs;
  logic        win_hit;
  reg_idx_t    req_idx;
  logic        wr_req;
  reg_idx_t    rd_idx_q;
  logic        rd_hit_q;
  logic [31:0] rd_word;

  mac_addr_t   mac_q;
  ip_addr_t    ip_q;
  ip_addr_t    gw_q;
  ip_addr_t    mask_q;
  ip_addr_t    mc_ip_q;
  ip_addr_t    mc_mask_q;
  udp_port_t   port_q;
  logic        en_q;
  logic        soft_rst_q;
  logic        clr_q;
  logic        arp_wr_q;
  arp_idx_t    arp_waddr_q;
  logic [31:0] arp_wdata_q;
  arp_idx_t    arp_raddr_q;

  // Replace the bytes enabled in sel
  function automatic logic [31:0] byte_merge(input logic [31:0] cur,
                                             input logic [31:0] din,
                                             input logic [3:0]  sel);
    logic [31:0] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (sel[b])
        res[8*b +: 8] = din[8*b +: 8];
    end
    return res;
  endfunction

  // No new cycle while ack is out
  assign req     = wb_cyc_i && wb_stb_i && !ack_q;
  assign win_ofs = wb_adr_i - `GMAC_REGS_LOW;
  assign win_hit = win_ofs <= (`GMAC_REGS_HIGH - `GMAC_REGS_LOW);
  assign req_idx = win_ofs[12:2];
  assign wr_req  = req && win_hit && wb_we_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q       <= 1'b0;
      soft_rst_q  <= 1'b0;
      clr_q       <= 1'b0;
      arp_wr_q    <= 1'b0;
      mac_q       <= FABRIC_MAC;
      ip_q        <= FABRIC_IP;
      gw_q        <= FABRIC_GATEWAY;
      mask_q      <= '0;
      mc_ip_q     <= MC_RECV_IP;
      mc_mask_q   <= MC_RECV_IP_MASK;
      port_q      <= FABRIC_PORT;
      en_q        <= FABRIC_ENABLE;
      arp_waddr_q <= '0;
      arp_wdata_q <= '0;
      arp_raddr_q <= '0;
    end else begin
      ack_q      <= req;
      soft_rst_q <= 1'b0;  // Pulses last one cycle
      clr_q      <= 1'b0;
      arp_wr_q   <= 1'b0;
      if (wr_req) begin
        case (req_idx)
          `GMAC_REG_MAC_ADDR_1: begin
            if (wb_sel_i[0])
              mac_q[39:32] <= wb_dat_i[7:0];
            if (wb_sel_i[1])
              mac_q[47:40] <= wb_dat_i[15:8];
          end
          `GMAC_REG_MAC_ADDR_0:      mac_q[31:0] <= byte_merge(mac_q[31:0], wb_dat_i, wb_sel_i);
          `GMAC_REG_IP_ADDR:         ip_q <= byte_merge(ip_q, wb_dat_i, wb_sel_i);
          `GMAC_REG_GATEWAY_ADDR:    gw_q <= byte_merge(gw_q, wb_dat_i, wb_sel_i);
          `GMAC_REG_NETMASK:         mask_q <= byte_merge(mask_q, wb_dat_i, wb_sel_i);
          `GMAC_REG_MC_RECV_IP:      mc_ip_q <= byte_merge(mc_ip_q, wb_dat_i, wb_sel_i);
          `GMAC_REG_MC_RECV_IP_MASK: mc_mask_q <= byte_merge(mc_mask_q, wb_dat_i, wb_sel_i);
          `GMAC_REG_PROMIS_EN: begin
            if (wb_sel_i[0])
              en_q <= wb_dat_i[0];
            if (wb_sel_i[2] && wb_dat_i[16])
              soft_rst_q <= 1'b1;
          end
          `GMAC_REG_PMASK_PORT: begin
            if (wb_sel_i[0])
              port_q[7:0] <= wb_dat_i[7:0];
            if (wb_sel_i[1])
              port_q[15:8] <= wb_dat_i[15:8];
          end
          `GMAC_REG_COUNT_RESET:     clr_q <= 1'b1;
          `GMAC_REG_ARP_WE: begin
            if (wb_sel_i[0] && wb_dat_i[0])
              arp_wr_q <= 1'b1;
          end
          `GMAC_REG_ARP_WDATA:       arp_wdata_q <= byte_merge(arp_wdata_q, wb_dat_i, wb_sel_i);
          `GMAC_REG_ARP_WADDR: begin
            if (wb_sel_i[0])
              arp_waddr_q <= wb_dat_i[7:0];
          end
          `GMAC_REG_ARP_RADDR: begin
            if (wb_sel_i[0])
              arp_raddr_q <= wb_dat_i[7:0];
          end
          // Identity, status and counter words are read only
          default: begin
          end
        endcase
      end
    end
  end

  // Index of the access being acknowledged
  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      rd_idx_q <= req_idx;
      rd_hit_q <= win_hit;
    end
  end

  always_comb begin
    case (rd_idx_q)
      `GMAC_REG_CORE_TYPE:       rd_word = `GMAC_CORE_TYPE_WORD;
      `GMAC_REG_TX_RX_MAX_BUF:   rd_word = `GMAC_MAX_BUF_WORD;
      `GMAC_REG_WORD_LENGTHS:    rd_word = `GMAC_WORD_SIZE_WORD;
      `GMAC_REG_MAC_ADDR_1:      rd_word = {16'b0, mac_q[47:32]};
      `GMAC_REG_MAC_ADDR_0:      rd_word = mac_q[31:0];
      `GMAC_REG_IP_ADDR:         rd_word = ip_q;
      `GMAC_REG_GATEWAY_ADDR:    rd_word = gw_q;
      `GMAC_REG_NETMASK:         rd_word = mask_q;
      `GMAC_REG_MC_RECV_IP:      rd_word = mc_ip_q;
      `GMAC_REG_MC_RECV_IP_MASK: rd_word = mc_mask_q;
      `GMAC_REG_PROMIS_EN:       rd_word = {31'b0, en_q};
      `GMAC_REG_PMASK_PORT:      rd_word = {16'b0, port_q};
      `GMAC_REG_PHY_STATUS_0:    rd_word = {31'b0, link_up_i};
      `GMAC_REG_ARP_SIZE:        rd_word = 32'(`GMAC_ARP_DEPTH);
      `GMAC_REG_TX_PKT_CNT:      rd_word = tx_pkt_cnt_i;
      `GMAC_REG_RX_PKT_CNT:      rd_word = rx_pkt_cnt_i;
      `GMAC_REG_RX_BAD_CNT:      rd_word = rx_bad_cnt_i;
      `GMAC_REG_ARP_WDATA:       rd_word = arp_wdata_q;
      `GMAC_REG_ARP_WADDR:       rd_word = {24'b0, arp_waddr_q};
      `GMAC_REG_ARP_RADDR:       rd_word = {24'b0, arp_raddr_q};
      `GMAC_REG_ARP_RDATA:       rd_word = arp_rdata_i;
      default:                   rd_word = '0;  // PHY control, buffers, unmapped
    endcase
  end

  assign wb_dat_o = (ack_q && rd_hit_q) ? rd_word : '0;
  assign wb_ack_o = ack_q;

  assign mac_addr_o   = mac_q;
  assign local_ip_o   = ip_q;
  assign gateway_o    = gw_q;
  assign netmask_o    = mask_q;
  assign mc_ip_o      = mc_ip_q;
  assign mc_mask_o    = mc_mask_q;
  assign udp_port_o   = port_q;
  assign fabric_en_o  = en_q;
  assign soft_reset_o = soft_rst_q;
  assign count_clr_o  = clr_q;
  assign arp_wr_o     = arp_wr_q;
  assign arp_waddr_o  = arp_waddr_q;
  assign arp_wdata_o  = arp_wdata_q;
  assign arp_raddr_o  = arp_raddr_q;

endmodule

`default_nettype wire

// File: src/gmac_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module gmac_ctrl_top (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic [31:0]         wb_adr_i,
  input  logic [3:0]          wb_sel_i,
  input  logic [31:0]         wb_dat_i,
  input  logic                wb_we_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  output logic [31:0]         wb_dat_o,
  output logic                wb_ack_o,
  output logic                wb_err_o,
  input  logic                link_up_i,
  input  logic                tx_pkt_i,
  input  logic                rx_pkt_i,
  input  logic                rx_bad_pkt_i,
  input  gmac_pkg::arp_idx_t  arp_lookup_idx_i,
  output gmac_pkg::mac_addr_t mac_addr_o,
  output gmac_pkg::ip_addr_t  local_ip_o,
  output gmac_pkg::ip_addr_t  gateway_o,
  output gmac_pkg::ip_addr_t  netmask_o,
  output gmac_pkg::ip_addr_t  mc_ip_o,
  output gmac_pkg::ip_addr_t  mc_mask_o,
  output gmac_pkg::udp_port_t udp_port_o,
  output logic                fabric_en_o,
  output logic                soft_reset_o,
  output logic [31:0]         arp_lookup_data_o
);
  import gmac_pkg::*;

  logic        count_clr;
  stat_cnt_t   tx_pkt_cnt;
  stat_cnt_t   rx_pkt_cnt;
  stat_cnt_t   rx_bad_cnt;
  logic        arp_wr;
  arp_idx_t    arp_waddr;
  logic [31:0] arp_wdata;
  arp_idx_t    arp_raddr;
  logic [31:0] arp_rdata;

  assign wb_err_o = 1'b0;  // Every access completes with ack

  gmac_wb_attach attach_i (
    .wb_clk_i, .wb_rst_i, .wb_adr_i, .wb_sel_i, .wb_dat_i, .wb_we_i,
    .wb_cyc_i, .wb_stb_i, .wb_dat_o, .wb_ack_o, .link_up_i,
    .mac_addr_o, .local_ip_o, .gateway_o, .netmask_o, .mc_ip_o, .mc_mask_o,
    .udp_port_o, .fabric_en_o, .soft_reset_o,
    .count_clr_o  (count_clr),
    .tx_pkt_cnt_i (tx_pkt_cnt),
    .rx_pkt_cnt_i (rx_pkt_cnt),
    .rx_bad_cnt_i (rx_bad_cnt),
    .arp_wr_o     (arp_wr),
    .arp_waddr_o  (arp_waddr),
    .arp_wdata_o  (arp_wdata),
    .arp_raddr_o  (arp_raddr),
    .arp_rdata_i  (arp_rdata)
  );

  gmac_arp_cache arp_i (
    .wb_clk_i,
    .wr_i          (arp_wr),
    .waddr_i       (arp_waddr),
    .wdata_i       (arp_wdata),
    .raddr_i       (arp_raddr),
    .lookup_idx_i  (arp_lookup_idx_i),
    .rdata_o       (arp_rdata),
    .lookup_data_o (arp_lookup_data_o)
  );

  gmac_stat_counters cnt_i (
    .wb_clk_i, .wb_rst_i,
    .clr_i        (count_clr),
    .tx_pkt_i, .rx_pkt_i, .rx_bad_pkt_i,
    .tx_cnt_o     (tx_pkt_cnt),
    .rx_cnt_o     (rx_pkt_cnt),
    .rx_bad_cnt_o (rx_bad_cnt)
  );

endmodule

`default_nettype wire

// File: verif/gmac_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module gmac_ctrl_props (
  input logic        clk_i,
  input logic        rst_i,
  input logic        cyc_i,
  input logic        stb_i,
  input logic        ack_i,
  input logic [31:0] dat_i,
  input logic        soft_reset_i,
  input logic        count_clr_i
);

  ack_single_a: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
    else $error("wb_ack_o high two cycles in a row");

  // Request seen while ack is low
  ack_follows_req_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && stb_i && !ack_i |=> ack_i)
    else $error("wb_ack_o missing one cycle after a request");

  dat_idle_zero_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !ack_i |-> dat_i == '0)
    else $error("wb_dat_o not zero outside an ack");

  soft_reset_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    soft_reset_i |=> !soft_reset_i)
    else $error("soft_reset_o longer than one cycle");

  count_clr_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    count_clr_i |=> !count_clr_i)
    else $error("count_clr_o longer than one cycle");

endmodule

bind gmac_wb_attach gmac_ctrl_props props_i (
  .clk_i        (wb_clk_i),
  .rst_i        (wb_rst_i),
  .cyc_i        (wb_cyc_i),
  .stb_i        (wb_stb_i),
  .ack_i        (wb_ack_o),
  .dat_i        (wb_dat_o),
  .soft_reset_i (soft_reset_o),
  .count_clr_i  (count_clr_o)
);

`default_nettype wire

// File: verif/gmac_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "gmac_defs.svh"

module gmac_ctrl_tb;
  import gmac_pkg::*;

  localparam int unsigned SEED = 32'haa93ae45;
  localparam logic [1:0] WR = 2'd0;
  localparam logic [1:0] RD = 2'd1;
  localparam logic [1:0] BURST = 2'd2;
  localparam logic [1:0] LINK = 2'd3;
  localparam mac_addr_t DEF_MAC = `GMAC_DEF_MAC;
  localparam reg_idx_t CFG_REGS [9] = '{`GMAC_REG_MAC_ADDR_1, `GMAC_REG_MAC_ADDR_0,
    `GMAC_REG_IP_ADDR, `GMAC_REG_GATEWAY_ADDR, `GMAC_REG_NETMASK, `GMAC_REG_MC_RECV_IP,
    `GMAC_REG_MC_RECV_IP_MASK, `GMAC_REG_PROMIS_EN, `GMAC_REG_PMASK_PORT};
  // Read only, PHY control and unmapped words
  localparam reg_idx_t FIXED_REGS [14] = '{`GMAC_REG_CORE_TYPE, `GMAC_REG_TX_RX_MAX_BUF,
    `GMAC_REG_WORD_LENGTHS, `GMAC_REG_TX_RX_BUF, `GMAC_REG_PHY_STATUS_1,
    `GMAC_REG_PHY_STATUS_0, `GMAC_REG_PHY_CONTROL_1, `GMAC_REG_PHY_CONTROL_0,
    `GMAC_REG_ARP_SIZE, `GMAC_REG_TX_PKT_CNT, `GMAC_REG_RX_PKT_CNT, `GMAC_REG_RX_BAD_CNT,
    11'd100, 11'd1030};

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] data;
    logic [31:0] exp;
  } step_t;

  logic        wb_clk_i, wb_rst_i, wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o, wb_err_o;
  logic [31:0] wb_adr_i, wb_dat_i, wb_dat_o, arp_lookup_data_o;
  logic [3:0]  wb_sel_i;
  logic        link_up_i, tx_pkt_i, rx_pkt_i, rx_bad_pkt_i, fabric_en_o, soft_reset_o;
  arp_idx_t    arp_lookup_idx_i;
  mac_addr_t   mac_addr_o;
  ip_addr_t    local_ip_o, gateway_o, netmask_o, mc_ip_o, mc_mask_o;
  udp_port_t   udp_port_o;

  step_t       steps[$];
  int          n_steps = 0;
  logic [31:0] model_rd [2048];  // Expected read word per index
  logic [31:0] arp_model [256];
  arp_idx_t    arp_used [4];

  gmac_ctrl_top dut_i (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [47:0] got, input logic [47:0] exp);
    assert (got === exp) else
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic logic [31:0] word_adr(input reg_idx_t idx);
    return {19'b0, idx, 2'b0};
  endfunction

  // Bits 0, 1, 2 drive tx, rx, rx_bad
  function automatic logic [2:0] burst_bits(input logic [31:0] p, input int c);
    return {p[c] & p[(c + 13) % 32], p[(c + 7) % 32], p[c]};
  endfunction

  function automatic logic [31:0] writable_mask(input reg_idx_t idx);
    case (idx)
      `GMAC_REG_MAC_ADDR_1, `GMAC_REG_PMASK_PORT: return 32'h0000_ffff;
      `GMAC_REG_MAC_ADDR_0, `GMAC_REG_IP_ADDR, `GMAC_REG_GATEWAY_ADDR, `GMAC_REG_NETMASK,
      `GMAC_REG_MC_RECV_IP, `GMAC_REG_MC_RECV_IP_MASK, `GMAC_REG_ARP_WDATA: return '1;
      `GMAC_REG_PROMIS_EN: return 32'h1;
      `GMAC_REG_ARP_WADDR, `GMAC_REG_ARP_RADDR: return 32'hff;
      default: return '0;
    endcase
  endfunction

  function automatic void reset_model();
    foreach (model_rd[k])
      model_rd[k] = '0;
    model_rd[`GMAC_REG_CORE_TYPE]       = `GMAC_CORE_TYPE_WORD;
    model_rd[`GMAC_REG_TX_RX_MAX_BUF]   = `GMAC_MAX_BUF_WORD;
    model_rd[`GMAC_REG_WORD_LENGTHS]    = `GMAC_WORD_SIZE_WORD;
    model_rd[`GMAC_REG_MAC_ADDR_1]      = {16'b0, DEF_MAC[47:32]};
    model_rd[`GMAC_REG_MAC_ADDR_0]      = DEF_MAC[31:0];
    model_rd[`GMAC_REG_IP_ADDR]         = `GMAC_DEF_IP;
    model_rd[`GMAC_REG_GATEWAY_ADDR]    = `GMAC_DEF_GATEWAY;
    model_rd[`GMAC_REG_MC_RECV_IP]      = `GMAC_DEF_MC_IP;
    model_rd[`GMAC_REG_MC_RECV_IP_MASK] = `GMAC_DEF_MC_MASK;
    model_rd[`GMAC_REG_PMASK_PORT]      = {16'b0, `GMAC_DEF_PORT};
    model_rd[`GMAC_REG_PHY_STATUS_0]    = 32'h1;  // link_up_i starts high
    model_rd[`GMAC_REG_ARP_SIZE]        = `GMAC_ARP_DEPTH;
  endfunction

  function automatic void push_write(input reg_idx_t idx, input logic [3:0] sel,
                                     input logic [31:0] d);
    logic [31:0] m;
    m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}} & writable_mask(idx);
    model_rd[idx] = (model_rd[idx] & ~m) | (d & m);
    if (idx == `GMAC_REG_COUNT_RESET) begin
      model_rd[`GMAC_REG_TX_PKT_CNT] = '0;
      model_rd[`GMAC_REG_RX_PKT_CNT] = '0;
      model_rd[`GMAC_REG_RX_BAD_CNT] = '0;
    end
    if (idx == `GMAC_REG_ARP_WE && sel[0] && d[0])
      arp_model[model_rd[`GMAC_REG_ARP_WADDR][7:0]] = model_rd[`GMAC_REG_ARP_WDATA];
    model_rd[`GMAC_REG_ARP_RDATA] = arp_model[model_rd[`GMAC_REG_ARP_RADDR][7:0]];
    steps.push_back({WR, word_adr(idx), sel, d, 32'h0});
  endfunction

  function automatic void enqueue_read(input logic [31:0] adr);
    logic [31:0] exp;
    exp = (adr <= `GMAC_REGS_HIGH) ? model_rd[adr[12:2]] : 32'h0;
    steps.push_back({RD, adr, 4'hf, 32'h0, exp});
  endfunction

  // PHY link state seen in bit 0 of the status word
  function automatic void set_link(input logic up);
    model_rd[`GMAC_REG_PHY_STATUS_0] = {31'b0, up};
    steps.push_back({LINK, 32'h0, 4'h0, {31'b0, up}, 32'h0});
  endfunction

  function automatic void append_burst(input logic [31:0] p);
    logic [2:0] b;
    for (int c = 0; c < 32; c++) begin
      b = burst_bits(p, c);
      for (int k = 0; k < 3; k++) begin
        if (b[k] && model_rd[`GMAC_REG_TX_PKT_CNT + 11'(k)] != '1)
          model_rd[`GMAC_REG_TX_PKT_CNT + 11'(k)] += 32'h1;
      end
    end
    steps.push_back({BURST, 32'h0, 4'h0, p, 32'h0});
    for (int k = 0; k < 3; k++)
      enqueue_read(word_adr(`GMAC_REG_TX_PKT_CNT + 11'(k)));
  endfunction

  function automatic void build_steps();
    reg_idx_t r;
    for (int k = 0; k <= 21; k++)
      enqueue_read(word_adr(11'(k)));
    for (int k = 0; k < 24; k++) begin
      r = CFG_REGS[$urandom_range(8)];
      push_write(r, 4'($urandom), $urandom);
      enqueue_read(word_adr(r));
    end
    foreach (FIXED_REGS[k]) begin
      push_write(FIXED_REGS[k], 4'hf, $urandom);
      enqueue_read(word_adr(FIXED_REGS[k]));
    end
    enqueue_read(32'h0000_2000 | ($urandom & 32'h0000_1ffc));  // Just above the window
    enqueue_read(32'h8000_0000);
    set_link(1'b0);
    enqueue_read(word_adr(`GMAC_REG_PHY_STATUS_0));
    set_link(1'b1);
    enqueue_read(word_adr(`GMAC_REG_PHY_STATUS_0));
    foreach (arp_used[k]) begin
      arp_used[k] = 8'($urandom);
      push_write(`GMAC_REG_ARP_WDATA, 4'hf, $urandom);
      push_write(`GMAC_REG_ARP_WADDR, 4'h1, 32'(arp_used[k]));
      push_write(`GMAC_REG_ARP_WE, 4'h1, 32'h1);
      push_write(`GMAC_REG_ARP_RADDR, 4'h1, 32'(arp_used[k]));
      enqueue_read(word_adr(`GMAC_REG_ARP_RDATA));
    end
    append_burst($urandom);
    append_burst($urandom);
    push_write(`GMAC_REG_COUNT_RESET, 4'hf, $urandom);
    for (int k = 0; k < 3; k++)
      enqueue_read(word_adr(`GMAC_REG_TX_PKT_CNT + 11'(k)));
    append_burst($urandom);
    push_write(`GMAC_REG_PROMIS_EN, 4'h5, 32'h0001_0001);  // Enable plus soft reset
    enqueue_read(word_adr(`GMAC_REG_PROMIS_EN));
  endfunction

  task automatic check_outputs();
    check_val("mac_addr_o", mac_addr_o,
              {model_rd[`GMAC_REG_MAC_ADDR_1][15:0], model_rd[`GMAC_REG_MAC_ADDR_0]});
    check_val("local_ip_o", 48'(local_ip_o), 48'(model_rd[`GMAC_REG_IP_ADDR]));
    check_val("gateway_o", 48'(gateway_o), 48'(model_rd[`GMAC_REG_GATEWAY_ADDR]));
    check_val("netmask_o", 48'(netmask_o), 48'(model_rd[`GMAC_REG_NETMASK]));
    check_val("mc_ip_o", 48'(mc_ip_o), 48'(model_rd[`GMAC_REG_MC_RECV_IP]));
    check_val("mc_mask_o", 48'(mc_mask_o), 48'(model_rd[`GMAC_REG_MC_RECV_IP_MASK]));
    check_val("udp_port_o", 48'(udp_port_o), 48'(model_rd[`GMAC_REG_PMASK_PORT][15:0]));
    check_val("fabric_en_o", 48'(fabric_en_o), 48'(model_rd[`GMAC_REG_PROMIS_EN][0]));
  endtask

  task automatic bus_cycle(input logic we, input step_t s, output logic [31:0] rdata);
    int waited;
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = s.adr;
    wb_sel_i = s.sel;
    wb_dat_i = s.data;
    waited = 0;
    do begin
      @(negedge wb_clk_i);
      waited++;
    end while (!wb_ack_o && waited < 4);
    assert (wb_ack_o) else abort_run("No acknowledge within 4 cycles of a Wishbone request");
    rdata = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic apply_step(input step_t s);
    logic [31:0] rdata;
    logic        sr_exp;
    if (s.kind == BURST) begin
      for (int c = 0; c < 32; c++) begin
        @(negedge wb_clk_i);
        {rx_bad_pkt_i, rx_pkt_i, tx_pkt_i} = burst_bits(s.data, c);
      end
      @(negedge wb_clk_i);
      {rx_bad_pkt_i, rx_pkt_i, tx_pkt_i} = 3'b000;
    end else if (s.kind == LINK) begin
      @(negedge wb_clk_i);
      link_up_i = s.data[0];
    end else begin
      bus_cycle(s.kind == WR, s, rdata);
      check_val("wb_err_o", 48'(wb_err_o), 48'h0);
      if (s.kind == RD) begin
        check_val("wb_dat_o", 48'(rdata), 48'(s.exp));
      end else begin
        sr_exp = (s.adr <= `GMAC_REGS_HIGH) && (s.adr[12:2] == `GMAC_REG_PROMIS_EN) &&
                 s.sel[2] && s.data[16];
        check_val("soft_reset_o", 48'(soft_reset_o), 48'(sr_exp));
        @(negedge wb_clk_i);
        check_val("soft_reset_o", 48'(soft_reset_o), 48'h0);  // Gone after one cycle
      end
    end
  endtask

  // Watchdog sized from the table
  initial begin
    wait (n_steps > 0);
    repeat (n_steps * 20 + 8) @(posedge wb_clk_i);
    abort_run("Timeout: the test sequence did not finish in time");
  end

  initial begin
    void'($urandom(SEED));
    wb_rst_i = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_we_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    link_up_i = 1'b1;
    {rx_bad_pkt_i, rx_pkt_i, tx_pkt_i} = 3'b000;
    arp_lookup_idx_i = '0;
    repeat (8) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    reset_model();
    check_outputs();
    build_steps();
    n_steps = steps.size();
    foreach (steps[i])
      apply_step(steps[i]);
    // Each written entry through the core lookup port
    foreach (arp_used[k]) begin
      @(negedge wb_clk_i);
      arp_lookup_idx_i = arp_used[k];
      @(negedge wb_clk_i);
      check_val("arp_lookup_data_o", 48'(arp_lookup_data_o), 48'(arp_model[arp_used[k]]));
    end
    check_outputs();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/gmac_pkg.sv
src/gmac_arp_cache.sv
src/gmac_stat_counters.sv
src/gmac_wb_attach.sv
src/gmac_ctrl_top.sv
verif/gmac_ctrl_props.sv
verif/gmac_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= gmac_ctrl_tb
FLIST     ?= flist.f
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
